// ==== rv_const_pkg.sv ====
`default_nettype none

package rv_const_pkg;

  // ********************
  // ISA widths and pc steps

  localparam int unsigned xlen = 32;
  localparam int unsigned cnt_w = $clog2(xlen) + 1;   // counts 0..xlen in the mul/div units

  localparam logic [cnt_w-1:0] md_steps = cnt_w'(xlen);

  localparam logic [xlen-1:0] pc_step_32 = 4;
  localparam logic [xlen-1:0] pc_step_16 = 2;

  // ********************
  // operation codes

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_op_t;

  typedef logic [1:0] md_op_t;

  localparam md_op_t md_mul    = 2'b00;
  localparam md_op_t md_mulh   = 2'b01;
  localparam md_op_t md_mulhsu = 2'b10;
  localparam md_op_t md_mulhu  = 2'b11;

  localparam md_op_t md_div  = 2'b00;   // same encoding space as the multiply codes
  localparam md_op_t md_divu = 2'b01;
  localparam md_op_t md_rem  = 2'b10;
  localparam md_op_t md_remu = 2'b11;

  // ********************
  // mcause values

  typedef logic [3:0] cause_t;

  localparam cause_t cause_illegal    = 4'd2;
  localparam cause_t cause_breakpoint = 4'd3;
  localparam cause_t cause_ecall_m    = 4'd11;

endpackage

`default_nettype wire

// ==== ex_wire_pkg.sv ====
`default_nettype none

package ex_wire_pkg;

  // ********************
  // issue record and stage register

  typedef struct packed {
    logic                          valid;    // slot holds an instruction
    logic                          legal;    // decode recognized the encoding
    logic [rv_const_pkg::xlen-1:0] pc;
    logic [rv_const_pkg::xlen-1:0] instr;
    logic [rv_const_pkg::xlen-1:0] rdata1;
    logic [rv_const_pkg::xlen-1:0] rdata2;
    logic [rv_const_pkg::xlen-1:0] imm;
    logic [4:0]                    waddr;
    logic                          wren;
    logic                          sel_imm;  // operand b comes from imm
    rv_const_pkg::alu_op_t         alu_op;
    rv_const_pkg::md_op_t          md_op;
    logic                          mul;
    logic                          div;
    logic                          lui;
    logic                          auipc;
    logic                          jal;
    logic                          jalr;
    logic                          ecall;
    logic                          ebreak;
  } ex_in_t;

  typedef struct packed {
    ex_in_t ins;
    logic   fresh;   // set only in the first cycle after capture
  } ex_reg_t;

  // ********************
  // stage outputs

  typedef struct packed {
    logic                          wren;
    logic [4:0]                    waddr;
    logic [rv_const_pkg::xlen-1:0] wdata;
  } ex_wb_t;

  typedef struct packed {
    logic                          exception;
    rv_const_pkg::cause_t          ecause;
    logic [rv_const_pkg::xlen-1:0] epc;
    logic [rv_const_pkg::xlen-1:0] etval;
  } ex_trap_t;

  // ********************
  // unit interfaces

  typedef struct packed {
    logic [rv_const_pkg::xlen-1:0] rdata1;
    logic [rv_const_pkg::xlen-1:0] rdata2;
    logic [rv_const_pkg::xlen-1:0] imm;
    logic                          sel_imm;
    rv_const_pkg::alu_op_t         alu_op;
  } alu_in_t;

  typedef struct packed {
    logic [rv_const_pkg::xlen-1:0] res;
  } alu_out_t;

  typedef struct packed {
    logic                          start;   // one-cycle pulse
    logic                          abort;   // back to idle at the next edge
    rv_const_pkg::md_op_t          op;
    logic [rv_const_pkg::xlen-1:0] rdata1;
    logic [rv_const_pkg::xlen-1:0] rdata2;
  } md_in_t;

  typedef struct packed {
    logic                          done;
    logic [rv_const_pkg::xlen-1:0] result;
  } md_out_t;

endpackage

`default_nettype wire

// ==== ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  ex_wire_pkg::alu_in_t  alu_in,
  output ex_wire_pkg::alu_out_t alu_out
);

  logic [rv_const_pkg::xlen-1:0] a;
  logic [rv_const_pkg::xlen-1:0] b;
  logic [4:0]                    shamt;
  logic                          lt_s;
  logic                          lt_u;

  assign a     = alu_in.rdata1;
  assign b     = alu_in.sel_imm ? alu_in.imm : alu_in.rdata2;   // immediate forms use imm
  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (alu_in.alu_op)
      rv_const_pkg::alu_add: begin
        alu_out.res = a + b;
      end
      rv_const_pkg::alu_sub: begin
        alu_out.res = a - b;
      end
      rv_const_pkg::alu_sll: begin
        alu_out.res = a << shamt;
      end
      rv_const_pkg::alu_slt: begin
        alu_out.res = {{(rv_const_pkg::xlen-1){1'b0}}, lt_s};
      end
      rv_const_pkg::alu_sltu: begin
        alu_out.res = {{(rv_const_pkg::xlen-1){1'b0}}, lt_u};
      end
      rv_const_pkg::alu_xor: begin
        alu_out.res = a ^ b;
      end
      rv_const_pkg::alu_srl: begin
        alu_out.res = a >> shamt;
      end
      rv_const_pkg::alu_sra: begin
        alu_out.res = $unsigned($signed(a) >>> shamt);   // keeps the sign bit
      end
      rv_const_pkg::alu_or: begin
        alu_out.res = a | b;
      end
      rv_const_pkg::alu_and: begin
        alu_out.res = a & b;
      end
      default: begin
        alu_out.res = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== ex_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mul (
  input  logic                 clk,
  input  logic                 rst,
  input  ex_wire_pkg::md_in_t  md_in,
  output ex_wire_pkg::md_out_t md_out
);

  logic                              busy;
  logic [rv_const_pkg::cnt_w-1:0]    cnt;
  logic                              last;
  logic                              a_neg;
  logic                              b_neg;
  logic [rv_const_pkg::xlen-1:0]     mag_a;
  logic [rv_const_pkg::xlen-1:0]     mag_b;
  logic                              neg;
  logic                              hi_word;
  logic [2*rv_const_pkg::xlen-1:0]   mcand;
  logic [rv_const_pkg::xlen-1:0]     mplier;
  logic [2*rv_const_pkg::xlen-1:0]   prod;
  logic [2*rv_const_pkg::xlen-1:0]   prod_fix;

  // mulh treats both operands as signed, mulhsu only the first
  assign a_neg = (md_in.op == rv_const_pkg::md_mulh || md_in.op == rv_const_pkg::md_mulhsu) &
                 md_in.rdata1[rv_const_pkg::xlen-1];
  assign b_neg = (md_in.op == rv_const_pkg::md_mulh) & md_in.rdata2[rv_const_pkg::xlen-1];
  assign mag_a = a_neg ? -md_in.rdata1 : md_in.rdata1;
  assign mag_b = b_neg ? -md_in.rdata2 : md_in.rdata2;
  assign last  = cnt == rv_const_pkg::md_steps;

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (md_in.abort) begin
      busy <= 1'b0;
    end else if (md_in.start) begin
      busy <= 1'b1;
      cnt  <= '0;
    end else if (busy && last) begin
      busy <= 1'b0;   // done cycle
    end else if (busy) begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (md_in.start) begin
      mcand   <= {{rv_const_pkg::xlen{1'b0}}, mag_a};
      mplier  <= mag_b;
      prod    <= '0;
      neg     <= a_neg ^ b_neg;
      hi_word <= md_in.op != rv_const_pkg::md_mul;
    end else if (busy && !last) begin
      if (mplier[0]) begin
        prod <= prod + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign prod_fix      = neg ? -prod : prod;
  assign md_out.done   = busy & last;
  assign md_out.result = hi_word ? prod_fix[2*rv_const_pkg::xlen-1:rv_const_pkg::xlen]
                                 : prod_fix[rv_const_pkg::xlen-1:0];

  // a new operation may only start while idle, or in the same cycle as an abort
  start_when_idle: assert property (@(posedge clk) disable iff (rst == 1'b0)
    md_in.start |-> (!busy || md_in.abort));

endmodule

`default_nettype wire

// ==== ex_div.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_div (
  input  logic                 clk,
  input  logic                 rst,
  input  ex_wire_pkg::md_in_t  md_in,
  output ex_wire_pkg::md_out_t md_out
);

  logic                              busy;
  logic [rv_const_pkg::cnt_w-1:0]    cnt;
  logic                              last;
  logic                              is_signed;
  logic                              a_neg;
  logic                              b_neg;
  logic                              b_zero;
  logic [rv_const_pkg::xlen-1:0]     mag_a;
  logic [rv_const_pkg::xlen-1:0]     mag_b;
  logic                              neg_q;
  logic                              neg_r;
  logic                              rem_sel;
  logic [rv_const_pkg::xlen-1:0]     quo;
  logic [rv_const_pkg::xlen-1:0]     rem;
  logic [rv_const_pkg::xlen-1:0]     dvs;
  logic [rv_const_pkg::xlen:0]       shifted;
  logic [rv_const_pkg::xlen:0]       diff;
  logic                              fits;
  logic [rv_const_pkg::xlen-1:0]     quo_fix;
  logic [rv_const_pkg::xlen-1:0]     rem_fix;

  assign is_signed = md_in.op == rv_const_pkg::md_div || md_in.op == rv_const_pkg::md_rem;
  assign a_neg     = is_signed & md_in.rdata1[rv_const_pkg::xlen-1];
  assign b_neg     = is_signed & md_in.rdata2[rv_const_pkg::xlen-1];
  assign b_zero    = md_in.rdata2 == '0;
  assign mag_a     = a_neg ? -md_in.rdata1 : md_in.rdata1;
  assign mag_b     = b_neg ? -md_in.rdata2 : md_in.rdata2;
  assign last      = cnt == rv_const_pkg::md_steps;

  // one restoring step: shift in the next dividend bit and try the subtract
  assign shifted = {rem, quo[rv_const_pkg::xlen-1]};
  assign diff    = shifted - {1'b0, dvs};
  assign fits    = shifted >= {1'b0, dvs};

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (md_in.abort) begin
      busy <= 1'b0;
    end else if (md_in.start) begin
      busy <= 1'b1;
      cnt  <= '0;
    end else if (busy && last) begin
      busy <= 1'b0;
    end else if (busy) begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (md_in.start) begin
      quo     <= mag_a;
      rem     <= '0;
      dvs     <= mag_b;
      neg_q   <= (a_neg ^ b_neg) & ~b_zero;   // x/0 must stay all ones
      neg_r   <= a_neg;                       // remainder takes the dividend's sign
      rem_sel <= md_in.op == rv_const_pkg::md_rem || md_in.op == rv_const_pkg::md_remu;
    end else if (busy && !last) begin
      rem <= fits ? diff[rv_const_pkg::xlen-1:0] : shifted[rv_const_pkg::xlen-1:0];
      quo <= {quo[rv_const_pkg::xlen-2:0], fits};
    end
  end

  // a zero divisor subtracts nothing, so the quotient fills with ones and the
  // remainder is the dividend; min/-1 gives a magnitude of 2**31 which already reads back
  // as the dividend with a zero remainder
  assign quo_fix = neg_q ? -quo : quo;
  assign rem_fix = neg_r ? -rem : rem;

  assign md_out.done   = busy & last;
  assign md_out.result = rem_sel ? rem_fix : quo_fix;

  start_when_idle: assert property (@(posedge clk) disable iff (rst == 1'b0)
    md_in.start |-> (!busy || md_in.abort));

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  ex_wire_pkg::ex_in_t   d,
  input  logic                  clear,
  output ex_wire_pkg::alu_in_t  alu_in,
  input  ex_wire_pkg::alu_out_t alu_out,
  output ex_wire_pkg::md_in_t   mul_in,
  output ex_wire_pkg::md_in_t   div_in,
  input  ex_wire_pkg::md_out_t  mul_out,
  input  ex_wire_pkg::md_out_t  div_out,
  output ex_wire_pkg::ex_wb_t   wb,
  output ex_wire_pkg::ex_trap_t trap,
  output logic                  stall
);

  ex_wire_pkg::ex_reg_t          r;
  logic [rv_const_pkg::xlen-1:0] npc;
  logic [rv_const_pkg::xlen-1:0] wdata;
  logic                          exc;
  rv_const_pkg::cause_t          cause;
  logic                          md_active;
  logic                          md_done;
  logic [rv_const_pkg::xlen-1:0] md_result;

  // ********************
  // stage register

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      r.ins.valid <= 1'b0;
      r.fresh     <= 1'b0;
    end else if (!stall) begin
      r.ins   <= d;
      r.fresh <= 1'b1;
    end else begin
      r.fresh <= 1'b0;   // held instruction is no longer new
    end
  end

  // ********************
  // exception priority

  always_comb begin
    exc   = 1'b0;
    cause = '0;
    if (!r.ins.legal) begin
      exc   = 1'b1;
      cause = rv_const_pkg::cause_illegal;
    end else if (r.ins.ebreak) begin
      exc   = 1'b1;
      cause = rv_const_pkg::cause_breakpoint;
    end else if (r.ins.ecall) begin
      exc   = 1'b1;
      cause = rv_const_pkg::cause_ecall_m;
    end
  end

  // ********************
  // arithmetic units

  assign md_active = r.ins.valid & ~exc & (r.ins.mul | r.ins.div);
  assign md_done   = r.ins.mul ? mul_out.done : div_out.done;
  assign md_result = r.ins.mul ? mul_out.result : div_out.result;
  assign stall     = md_active & ~md_done & ~clear;   // clear releases the hold at once

  always_comb begin
    alu_in.rdata1  = r.ins.rdata1;
    alu_in.rdata2  = r.ins.rdata2;
    alu_in.imm     = r.ins.imm;
    alu_in.sel_imm = r.ins.sel_imm;
    alu_in.alu_op  = r.ins.alu_op;

    mul_in.start  = r.fresh & md_active & r.ins.mul & ~clear;
    mul_in.abort  = clear;
    mul_in.op     = r.ins.md_op;
    mul_in.rdata1 = r.ins.rdata1;
    mul_in.rdata2 = r.ins.rdata2;

    div_in.start  = r.fresh & md_active & ~r.ins.mul & ~clear;   // mul wins if both flags set
    div_in.abort  = clear;
    div_in.op     = r.ins.md_op;
    div_in.rdata1 = r.ins.rdata1;
    div_in.rdata2 = r.ins.rdata2;
  end

  // ********************
  // write-back and trap

  assign npc = r.ins.pc + ((r.ins.instr[1:0] == 2'b11) ? rv_const_pkg::pc_step_32
                                                       : rv_const_pkg::pc_step_16);

  always_comb begin
    if (r.ins.auipc) begin
      wdata = r.ins.pc + r.ins.imm;
    end else if (r.ins.lui) begin
      wdata = r.ins.imm;
    end else if (r.ins.jal || r.ins.jalr) begin
      wdata = npc;   // link value
    end else begin
      wdata = alu_out.res;
    end
    if (md_active && md_done) begin
      wdata = md_result;
    end
  end

  always_comb begin
    wb.wren  = r.ins.valid & r.ins.wren & (|r.ins.waddr) & ~exc & ~stall & ~clear;
    wb.waddr = r.ins.waddr;
    wb.wdata = wdata;

    trap.exception = r.ins.valid & exc & ~clear;
    trap.ecause    = cause;
    trap.epc       = r.ins.pc;
    trap.etval     = exc ? r.ins.instr : '0;
  end

  // a unit only reports a result while the stage is holding for that unit
  mul_done_expected: assert property (@(posedge clk) disable iff (rst == 1'b0)
    mul_out.done |-> (md_active && r.ins.mul));
  div_done_expected: assert property (@(posedge clk) disable iff (rst == 1'b0)
    div_out.done |-> (md_active && !r.ins.mul));

endmodule

`default_nettype wire

// ==== ex_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  ex_wire_pkg::ex_in_t   d,
  input  logic                  clear,
  output ex_wire_pkg::ex_wb_t   wb,
  output ex_wire_pkg::ex_trap_t trap,
  output logic                  stall
);

  ex_wire_pkg::alu_in_t  alu_in;
  ex_wire_pkg::alu_out_t alu_out;
  ex_wire_pkg::md_in_t   mul_in;
  ex_wire_pkg::md_out_t  mul_out;
  ex_wire_pkg::md_in_t   div_in;
  ex_wire_pkg::md_out_t  div_out;

  ex_stage stage0 (
    .clk     (clk),
    .rst     (rst),
    .d       (d),
    .clear   (clear),
    .alu_in  (alu_in),
    .alu_out (alu_out),
    .mul_in  (mul_in),
    .div_in  (div_in),
    .mul_out (mul_out),
    .div_out (div_out),
    .wb      (wb),
    .trap    (trap),
    .stall   (stall)
  );

  ex_alu alu0 (
    .alu_in  (alu_in),
    .alu_out (alu_out)
  );

  ex_mul mul0 (
    .clk    (clk),
    .rst    (rst),
    .md_in  (mul_in),
    .md_out (mul_out)
  );

  ex_div div0 (
    .clk    (clk),
    .rst    (rst),
    .md_in  (div_in),
    .md_out (div_out)
  );

endmodule

`default_nettype wire

// ==== tb_ex_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ex_unit;

  typedef struct packed {
    ex_wire_pkg::ex_wb_t   wb;
    ex_wire_pkg::ex_trap_t trap;
  } exp_t;

  localparam int n_alu       = 200;
  localparam int n_link      = 16;
  localparam int n_mul       = 48;
  localparam int n_div       = 56;
  localparam int n_trap      = 8;
  localparam int n_flush     = 8;
  localparam int n_issue     = n_alu + n_link + n_mul + n_div + n_trap + n_flush + 6;
  localparam int cycle_limit = 60 * n_issue + 200;

  logic                  clk;
  logic                  rst;
  logic                  clear;
  ex_wire_pkg::ex_in_t   d;
  ex_wire_pkg::ex_wb_t   wb;
  ex_wire_pkg::ex_trap_t trap;
  logic                  stall;

  integer              seed      = 74;
  int                  cycles    = 0;
  int                  n_passed  = 0;
  int                  n_failed  = 0;
  int                  fail_mark = 0;
  ex_wire_pkg::ex_in_t pend[$];   // captured by the stage and not yet retired

  ex_unit dut0 (
    .clk   (clk),
    .rst   (rst),
    .d     (d),
    .clear (clear),
    .wb    (wb),
    .trap  (trap),
    .stall (stall)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ********************
  // reference model

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic logic [31:0] alu_ref(input ex_wire_pkg::ex_in_t ins);
    logic [31:0] a;
    logic [31:0] b;
    a = ins.rdata1;
    b = ins.sel_imm ? ins.imm : ins.rdata2;
    case (ins.alu_op)
      rv_const_pkg::alu_add:  return a + b;
      rv_const_pkg::alu_sub:  return a - b;
      rv_const_pkg::alu_sll:  return a << b[4:0];
      rv_const_pkg::alu_slt:  return {31'b0, $signed(a) < $signed(b)};
      rv_const_pkg::alu_sltu: return {31'b0, a < b};
      rv_const_pkg::alu_xor:  return a ^ b;
      rv_const_pkg::alu_srl:  return a >> b[4:0];
      rv_const_pkg::alu_sra:  return $signed(a) >>> b[4:0];
      rv_const_pkg::alu_or:   return a | b;
      rv_const_pkg::alu_and:  return a & b;
      default:                return '0;
    endcase
  endfunction

  function automatic logic [31:0] mul_ref(input logic [1:0] op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] ua;
    logic [63:0] ub;
    sa = {{32{a[31]}}, a};   // low 64 bits of the product are exact for both signs
    sb = {{32{b[31]}}, b};
    ua = {32'b0, a};
    ub = {32'b0, b};
    case (op)
      rv_const_pkg::md_mul:    return ua * ub;
      rv_const_pkg::md_mulh:   return (sa * sb) >> 32;
      rv_const_pkg::md_mulhsu: return (sa * ub) >> 32;
      default:                 return (ua * ub) >> 32;
    endcase
  endfunction

  function automatic logic [31:0] div_ref(input logic [1:0] op, input logic [31:0] a,
                                          input logic [31:0] b);
    longint          sa;
    longint          sb;
    longint unsigned ua;
    longint unsigned ub;
    if (b == 32'd0) begin
      return (op == rv_const_pkg::md_div || op == rv_const_pkg::md_divu) ? '1 : a;
    end
    sa = $signed(a);
    sb = $signed(b);
    ua = a;
    ub = b;
    case (op)
      rv_const_pkg::md_div:  return sa / sb;   // min / -1 wraps back to the dividend
      rv_const_pkg::md_divu: return ua / ub;
      rv_const_pkg::md_rem:  return sa % sb;
      default:               return ua % ub;
    endcase
  endfunction

  function automatic exp_t exp_result(input ex_wire_pkg::ex_in_t ins);
    exp_t        e;
    logic [31:0] npc;
    e = '0;
    if (!ins.legal || ins.ebreak || ins.ecall) begin
      e.trap.exception = 1'b1;
      e.trap.epc       = ins.pc;
      e.trap.etval     = ins.instr;
      if (!ins.legal) begin
        e.trap.ecause = rv_const_pkg::cause_illegal;
      end else if (ins.ebreak) begin
        e.trap.ecause = rv_const_pkg::cause_breakpoint;
      end else begin
        e.trap.ecause = rv_const_pkg::cause_ecall_m;
      end
      return e;
    end
    npc = ins.pc + ((ins.instr[1:0] == 2'b11) ? 32'd4 : 32'd2);
    if (ins.mul) begin
      e.wb.wdata = mul_ref(ins.md_op, ins.rdata1, ins.rdata2);
    end else if (ins.div) begin
      e.wb.wdata = div_ref(ins.md_op, ins.rdata1, ins.rdata2);
    end else if (ins.auipc) begin
      e.wb.wdata = ins.pc + ins.imm;
    end else if (ins.lui) begin
      e.wb.wdata = ins.imm;
    end else if (ins.jal || ins.jalr) begin
      e.wb.wdata = npc;
    end else begin
      e.wb.wdata = alu_ref(ins);
    end
    e.wb.wren  = ins.wren && (ins.waddr != 5'd0);
    e.wb.waddr = ins.waddr;
    return e;
  endfunction

  // ********************
  // comparison

  task automatic compare_outputs(input exp_t e, input logic [31:0] pc);
    logic bad;
    bad = 1'b0;
    if (wb.wren !== e.wb.wren) begin
      $display("** Error: wb.wren expected %h, got %h (pc %h)", e.wb.wren, wb.wren, pc);
      bad = 1'b1;
    end
    if (e.wb.wren && wb.waddr !== e.wb.waddr) begin
      $display("** Error: wb.waddr expected %h, got %h (pc %h)", e.wb.waddr, wb.waddr, pc);
      bad = 1'b1;
    end
    if (e.wb.wren && wb.wdata !== e.wb.wdata) begin
      $display("** Error: wb.wdata expected %h, got %h (pc %h)", e.wb.wdata, wb.wdata, pc);
      bad = 1'b1;
    end
    if (trap.exception !== e.trap.exception) begin
      $display("** Error: trap.exception expected %h, got %h (pc %h)",
               e.trap.exception, trap.exception, pc);
      bad = 1'b1;
    end
    if (e.trap.exception && trap.ecause !== e.trap.ecause) begin
      $display("** Error: trap.ecause expected %h, got %h", e.trap.ecause, trap.ecause);
      bad = 1'b1;
    end
    if (e.trap.exception && trap.epc !== e.trap.epc) begin
      $display("** Error: trap.epc expected %h, got %h", e.trap.epc, trap.epc);
      bad = 1'b1;
    end
    if (e.trap.exception && trap.etval !== e.trap.etval) begin
      $display("** Error: trap.etval expected %h, got %h", e.trap.etval, trap.etval);
      bad = 1'b1;
    end
    if (bad) begin
      n_failed++;
    end else begin
      n_passed++;
    end
  endtask

  always @(posedge clk) begin
    if (rst === 1'b1) begin
      if (stall === 1'b1) begin
        if (pend.size() == 0 || !(pend[0].mul || pend[0].div)) begin
          $display("stall is high with no multiply or divide in the stage");
          n_failed++;
        end
        if (wb.wren !== 1'b0 || trap.exception !== 1'b0) begin
          $display("write-back or trap reported while the stage is stalled");
          n_failed++;
        end
      end else begin
        if (pend.size() != 0) begin
          if (clear === 1'b1) begin
            compare_outputs('0, pend[0].pc);   // flushed, nothing may come out
          end else begin
            compare_outputs(exp_result(pend[0]), pend[0].pc);
          end
          void'(pend.pop_front());
        end else if (wb.wren !== 1'b0 || trap.exception !== 1'b0) begin
          $display("write-back or trap reported with no instruction in the stage");
          n_failed++;
        end
        if (d.valid) begin
          pend.push_back(d);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("run timed out waiting for the DUT after %0d cycles", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ********************
  // stimulus

  function automatic ex_wire_pkg::ex_in_t base_ins();
    ex_wire_pkg::ex_in_t ins;
    logic [31:0]         r;
    ins       = '0;
    r         = rnd();
    ins.valid = 1'b1;
    ins.legal = 1'b1;
    ins.wren  = 1'b1;
    ins.pc    = {r[31:2], 2'b00};
    ins.instr = rnd() | 32'h3;   // 4-byte encoding unless a test changes it
    ins.rdata1 = rnd();
    ins.rdata2 = rnd();
    ins.imm    = rnd();
    ins.waddr  = 5'(rnd());
    return ins;
  endfunction

  task automatic issue(input ex_wire_pkg::ex_in_t ins);
    d = ins;
    @(negedge clk);
    while (stall === 1'b1) begin
      @(negedge clk);   // upstream holds d
    end
  endtask

  task automatic flush_md(input ex_wire_pkg::ex_in_t md_ins, input ex_wire_pkg::ex_in_t nxt,
                          input int hold);
    d = md_ins;
    @(negedge clk);
    repeat (hold) @(negedge clk);
    clear = 1'b1;
    d     = nxt;
    #1;
    if (stall !== 1'b0) begin
      $display("stall did not fall while clear was asserted");
      n_failed++;
    end
    @(negedge clk);
    clear = 1'b0;
    while (stall === 1'b1) begin
      @(negedge clk);
    end
  endtask

  task automatic end_test(input string name);
    issue('0);   // bubble lets the last instruction retire
    if (n_failed == fail_mark) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, n_failed - fail_mark);
    end
    fail_mark = n_failed;
  endtask

  initial begin
    ex_wire_pkg::ex_in_t ins;
    ex_wire_pkg::ex_in_t nxt;
    logic [3:0]          k;
    int                  i;
    rst   = 1'b0;
    clear = 1'b0;
    d     = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;

    for (i = 0; i < n_alu; i++) begin
      ins         = base_ins();
      k           = 4'(i % 10);
      ins.alu_op  = rv_const_pkg::alu_op_t'(k);
      ins.sel_imm = 1'((i / 10) % 2);
      issue(ins);
    end
    end_test("alu");

    for (i = 0; i < n_link; i++) begin
      ins       = base_ins();
      ins.lui   = (i % 4) == 0;
      ins.auipc = (i % 4) == 1;
      ins.jal   = (i % 4) == 2;
      ins.jalr  = (i % 4) == 3;
      if ((i / 4) % 2 == 1) begin
        ins.instr[1:0] = 2'b01;   // compressed encoding
      end
      ins.waddr = (i >= 8) ? 5'd0 : ins.waddr | 5'd1;
      issue(ins);
    end
    end_test("link");

    for (i = 0; i < n_mul; i++) begin
      ins       = base_ins();
      ins.mul   = 1'b1;
      ins.md_op = 2'(i % 4);
      if (i >= 40) begin
        ins.rdata1 = (i < 44) ? 32'h8000_0000 : 32'hffff_ffff;
        ins.rdata2 = (i < 44) ? 32'h8000_0000 : 32'hffff_ffff;
      end
      issue(ins);
    end
    end_test("mul");

    for (i = 0; i < n_div; i++) begin
      ins       = base_ins();
      ins.div   = 1'b1;
      ins.md_op = 2'(i % 4);
      if (i < 40 && i % 3 == 0) begin
        ins.rdata2 = rnd() % 256;
      end else if (i >= 40 && i < 48) begin
        ins.rdata2 = '0;
      end else if (i >= 48) begin
        ins.rdata1 = 32'h8000_0000;
        ins.rdata2 = 32'hffff_ffff;
      end
      issue(ins);
    end
    end_test("div");

    for (i = 0; i < n_trap; i++) begin
      ins        = base_ins();
      ins.legal  = !(i == 0 || i == 3 || i == 5 || i == 6);
      ins.ebreak = i == 1 || i == 3 || i == 4;
      ins.ecall  = i == 2 || i == 3 || i == 4 || i == 5 || i == 7;
      if (i == 6) begin
        ins.instr[1:0] = 2'b10;
      end
      if (i == 7) begin
        ins.waddr = 5'd0;
      end
      issue(ins);
    end
    end_test("trap");

    for (i = 0; i < n_flush / 2; i++) begin
      ins       = base_ins();
      ins.mul   = (i % 2) == 0;
      ins.div   = (i % 2) == 1;
      ins.md_op = 2'(rnd());
      nxt       = base_ins();
      nxt.mul   = i == 2;
      nxt.div   = i == 1;
      nxt.md_op = 2'(rnd());
      flush_md(ins, nxt, (i == 2) ? 0 : 5 + 8 * i);
    end
    end_test("flush");

    $display("%0d checks passed, %0d failed", n_passed, n_failed);
    if (n_failed == 0 && pend.size() == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
rv_const_pkg.sv
ex_wire_pkg.sv
ex_alu.sv
ex_mul.sv
ex_div.sv
ex_stage.sv
ex_unit.sv
tb_ex_unit.sv
